// File: hw/miner_pkg.sv
`default_nettype none

package miner_pkg;

	// block header as written by the host, byte 0 in the low bits
	localparam int header_bytes = 96;
	typedef logic [header_bytes*8-1:0] header_t;

	typedef logic [31:0] nonce_t;

	// nonce field sits in header bytes 44..47
	localparam int nonce_lsb = 352;

	// register map
	localparam logic [7:0] addr_status = 8'd101;      // bit0 loading, bit1 load_done
	localparam logic [7:0] addr_control = 8'd102;     // wr bit0 start, rd bit0 start, bit1 stop
	localparam logic [7:0] addr_arm = 8'd103;         // bit0 armed
	localparam logic [7:0] addr_nonce_base = 8'd104;  // 4 bytes per miner
	localparam logic [7:0] addr_result_base = 8'd148; // 5 bytes per miner

	// host register port strobes
	typedef struct packed {
		logic write;
		logic read;
		logic chipselect;
		logic [7:0] address;
		logic [7:0] writedata;
	} bus_req_t;

	// one miner core's report
	typedef struct packed {
		logic found;
		nonce_t nonce;
	} miner_result_t;

	// load control
	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_loading
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/header_loader.sv
`timescale 1ns/1ps
`default_nettype none

module header_loader (
	input wire clk,
	input wire rst_n,
	input wire miner_pkg::bus_req_t bus,
	output miner_pkg::ctrl_state_e state,
	output miner_pkg::header_t header,
	output logic load_done
);

	logic wr_strobe;
	logic start_req;
	logic hdr_byte;
	logic last_byte;

	assign wr_strobe = bus.write && bus.chipselect;

	// start request only counts while idle
	assign start_req = wr_strobe && (bus.address == miner_pkg::addr_control) &&
		bus.writedata[0];

	// header byte addresses 0..95
	assign hdr_byte = wr_strobe && (int'(bus.address) < miner_pkg::header_bytes);
	assign last_byte = hdr_byte && (int'(bus.address) == miner_pkg::header_bytes - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= miner_pkg::st_idle;
			load_done <= 1'b0;
			header <= '0;
		end else begin
			load_done <= 1'b0; // single cycle pulse

			case (state)
				miner_pkg::st_idle: begin
					if (start_req) begin
						state <= miner_pkg::st_start;
					end
				end

				miner_pkg::st_start: begin
					// wipe the old job before the new bytes arrive
					header <= '0;
					state <= miner_pkg::st_loading;
				end

				miner_pkg::st_loading: begin
					if (hdr_byte) begin
						header[8*int'(bus.address) +: 8] <= bus.writedata;
					end
					if (last_byte) begin
						state <= miner_pkg::st_idle; // byte 95 closes the load
						load_done <= 1'b1;
					end
				end

				default: begin
					state <= miner_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/nonce_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module nonce_allocator #(
	parameter int num_miners = 4,
	parameter int nonce_range = 10000000
) (
	input wire clk,
	input wire rst_n,
	input wire miner_pkg::header_t header,
	output miner_pkg::nonce_t [num_miners-1:0] start_nonces
);

	miner_pkg::nonce_t base_nonce;

	// nonce field straight out of the header, low byte first
	assign base_nonce = header[miner_pkg::nonce_lsb +: 32];

	// each core gets its own slice of nonce_range values, wrapping mod 2^32
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start_nonces <= '0;
		end else begin
			for (int k = 0; k < num_miners; k++) begin
				start_nonces[k] <= base_nonce +
					miner_pkg::nonce_t'(k) * miner_pkg::nonce_t'(nonce_range);
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/result_capture.sv
`timescale 1ns/1ps
`default_nettype none

module result_capture #(
	parameter int num_miners = 4
) (
	input wire clk,
	input wire rst_n,
	input wire miner_pkg::ctrl_state_e state,
	input wire miner_pkg::miner_result_t [num_miners-1:0] results,
	output miner_pkg::miner_result_t [num_miners-1:0] captured,
	output logic armed,
	output logic stop
);

	logic hit;

	// any core reporting a find
	always_comb begin
		hit = 1'b0;
		for (int k = 0; k < num_miners; k++) begin
			hit = hit | results[k].found;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed <= 1'b1;
			stop <= 1'b0;
			captured <= '0;
		end else if (state == miner_pkg::st_start) begin
			// new job, rearm and forget the last run
			armed <= 1'b1;
			stop <= 1'b0;
			captured <= '0;
		end else if (stop) begin
			captured <= results; // track the cores after the find
		end else if (armed && hit) begin
			// first hit since the start freezes the run
			captured <= results;
			armed <= 1'b0;
			stop <= 1'b1;
		end else begin
			captured <= '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/readback_mux.sv
`timescale 1ns/1ps
`default_nettype none

module readback_mux #(
	parameter int num_miners = 4
) (
	input wire clk,
	input wire rst_n,
	input wire miner_pkg::bus_req_t bus,
	input wire miner_pkg::ctrl_state_e state,
	input wire load_done,
	input wire miner_pkg::header_t header,
	input wire miner_pkg::nonce_t [num_miners-1:0] start_nonces,
	input wire miner_pkg::miner_result_t [num_miners-1:0] captured,
	input wire armed,
	input wire stop,
	output logic [7:0] readdata
);

	logic rd_en;
	logic [7:0] sel_byte;

	// no readback while the header is being written
	assign rd_en = bus.read && bus.chipselect && (state != miner_pkg::st_loading);

	always_comb begin
		sel_byte = 8'h00; // unmapped reads return 0

		if (int'(bus.address) < miner_pkg::header_bytes) begin
			sel_byte = header[8*int'(bus.address) +: 8];
		end else if (bus.address == miner_pkg::addr_status) begin
			sel_byte = {6'b0, load_done, state == miner_pkg::st_loading};
		end else if (bus.address == miner_pkg::addr_control) begin
			sel_byte = {6'b0, stop, state == miner_pkg::st_start};
		end else if (bus.address == miner_pkg::addr_arm) begin
			sel_byte = {7'b0, armed};
		end

		// per-miner windows, nonce bytes low first
		for (int k = 0; k < num_miners; k++) begin
			for (int b = 0; b < 4; b++) begin
				if (int'(bus.address) == int'(miner_pkg::addr_nonce_base) + 4*k + b) begin
					sel_byte = start_nonces[k][8*b +: 8];
				end
				if (int'(bus.address) == int'(miner_pkg::addr_result_base) + 5*k + b) begin
					sel_byte = captured[k].nonce[8*b +: 8];
				end
			end
			// fifth result byte carries the found flag
			if (int'(bus.address) == int'(miner_pkg::addr_result_base) + 5*k + 4) begin
				sel_byte = {7'b0, captured[k].found};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			readdata <= 8'h00;
		end else if (rd_en) begin
			readdata <= sel_byte; // held until the next read
		end
	end

endmodule

`default_nettype wire

// File: hw/miner_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module miner_ctrl_top #(
	parameter int num_miners = 4,
	parameter int nonce_range = 10000000
) (
	input wire clk,
	input wire rst_n,
	input wire miner_pkg::bus_req_t bus,
	output logic [7:0] readdata,
	output miner_pkg::header_t header,
	output miner_pkg::nonce_t [num_miners-1:0] start_nonces,
	output logic load_done,
	input wire miner_pkg::miner_result_t [num_miners-1:0] results
);

	miner_pkg::ctrl_state_e state;
	miner_pkg::miner_result_t [num_miners-1:0] captured;
	logic armed;
	logic stop;

	// host writes, start and header buffer
	header_loader header_loader_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.state(state),
		.header(header),
		.load_done(load_done)
	);

	nonce_allocator #(
		.num_miners(num_miners),
		.nonce_range(nonce_range)
	) nonce_allocator_i (
		.clk(clk),
		.rst_n(rst_n),
		.header(header),
		.start_nonces(start_nonces)
	);

	result_capture #(
		.num_miners(num_miners)
	) result_capture_i (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.results(results),
		.captured(captured),
		.armed(armed),
		.stop(stop)
	);

	readback_mux #(
		.num_miners(num_miners)
	) readback_mux_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.state(state),
		.load_done(load_done),
		.header(header),
		.start_nonces(start_nonces),
		.captured(captured),
		.armed(armed),
		.stop(stop),
		.readdata(readdata)
	);

endmodule

`default_nettype wire

// File: testbench/miner_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module miner_ctrl_sva (
	input wire clk,
	input wire rst_n,
	input wire load_done,
	input wire armed,
	input wire stop
);

	int fail_count = 0;

	// done is a single cycle pulse
	load_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		load_done |=> !load_done)
		else begin
			$error("load_done stayed high for more than one cycle");
			fail_count++;
		end

	// a frozen run is never armed at the same time
	stop_armed_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(stop && armed))
		else begin
			$error("stop and armed are both high");
			fail_count++;
		end

	reset_flags: assert property (@(posedge clk)
		!rst_n |=> (!stop && !load_done))
		else begin
			$error("stop or load_done not cleared by reset");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: testbench/miner_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module miner_ctrl_tb;

	localparam int num_miners = 4; // matches the top level defaults
	localparam int nonce_range = 10000000;

	logic clk = 1'b0;
	logic rst_n;
	miner_pkg::bus_req_t bus;
	logic [7:0] readdata;
	miner_pkg::header_t header;
	miner_pkg::nonce_t [num_miners-1:0] start_nonces;
	logic load_done;
	miner_pkg::miner_result_t [num_miners-1:0] results;

	miner_pkg::header_t exp_header = '0; // tb copy of the written header
	logic exp_armed = 1'b1;
	logic exp_stop = 1'b0;
	logic [31:0] lfsr = 32'h9f8c;
	int error_count = 0;
	logic chk_valid = 1'b0;
	logic [7:0] chk_addr;
	logic [7:0] chk_exp;

	always #2 clk = ~clk;

	miner_ctrl_top miner_ctrl_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.readdata(readdata),
		.header(header),
		.start_nonces(start_nonces),
		.load_done(load_done),
		.results(results)
	);

	bind miner_ctrl_top miner_ctrl_sva miner_ctrl_sva_i (
		.clk(clk),
		.rst_n(rst_n),
		.load_done(load_done),
		.armed(armed),
		.stop(stop)
	);

	// galois form for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// header nonce field plus one slice per miner, mod 2^32
	function automatic miner_pkg::nonce_t exp_start_nonce(input int k);
		exp_start_nonce = exp_header[miner_pkg::nonce_lsb +: 32] + 32'(k) * 32'(nonce_range);
	endfunction

	// expected readback byte for any address
	function automatic logic [7:0] ref_byte(input logic [7:0] addr);
		int a;
		int k;
		int b;
		logic [31:0] sn;
		a = int'(addr);
		ref_byte = 8'h00; // status and unmapped read 0 once the load is over
		if (a < miner_pkg::header_bytes) begin
			ref_byte = exp_header[8*a +: 8];
		end else if (addr == miner_pkg::addr_control) begin
			ref_byte = {6'b0, exp_stop, 1'b0};
		end else if (addr == miner_pkg::addr_arm) begin
			ref_byte = {7'b0, exp_armed};
		end else if (a >= 104 && a < 104 + 4*num_miners) begin
			k = (a - 104) / 4;
			b = (a - 104) % 4;
			sn = exp_start_nonce(k);
			ref_byte = sn[8*b +: 8];
		end else if (a >= 148 && a < 148 + 5*num_miners) begin
			k = (a - 148) / 5;
			b = (a - 148) % 5;
			if (exp_stop) begin
				ref_byte = (b == 4) ? {7'b0, results[k].found} : results[k].nonce[8*b +: 8];
			end
		end
	endfunction

	// readdata is due one edge after the read is sampled
	always @(posedge clk) begin
		if (chk_valid) begin
			assert (readdata == chk_exp) else begin
				$display("MISMATCH readdata addr=%h exp=%h got=%h",
					chk_addr, chk_exp, readdata);
				error_count++;
			end
		end
		chk_valid <= rst_n && bus.read && bus.chipselect;
		chk_addr <= bus.address;
		chk_exp <= ref_byte(bus.address);
	end

	task automatic finish_run();
		int sva_fails;
		sva_fails = miner_ctrl_top_i.miner_ctrl_sva_i.fail_count;
		$display("errors: %0d, assertion failures: %0d", error_count, sva_fails);
		if (error_count == 0 && sva_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic write_byte(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk);
		bus <= '{write: 1'b1, read: 1'b0, chipselect: 1'b1, address: a, writedata: d};
		if (int'(a) < miner_pkg::header_bytes) begin
			exp_header[8*int'(a) +: 8] <= d;
		end
		@(posedge clk);
		bus <= '0;
	endtask

	task automatic read_byte(input logic [7:0] a);
		@(posedge clk);
		bus <= '{write: 1'b0, read: 1'b1, chipselect: 1'b1, address: a, writedata: 8'h00};
		@(posedge clk);
		bus <= '0;
	endtask

	task automatic start_load();
		exp_header <= '0; // new job wipes the buffer and rearms
		exp_armed <= 1'b1;
		exp_stop <= 1'b0;
		write_byte(miner_pkg::addr_control, 8'h01);
	endtask

	task automatic wait_load_done();
		int n;
		for (n = 0; n < 20 && !load_done; n++) begin
			@(posedge clk);
		end
		if (!load_done) begin
			$display("timeout: load_done never rose after the last header byte");
			error_count++;
			finish_run();
		end else begin
			@(posedge clk);
			assert (!load_done) else begin
				$display("load_done stayed high for a second cycle");
				error_count++;
			end
		end
	endtask

	// job the cores see once the load is over
	task automatic check_job_outputs();
		miner_pkg::nonce_t sn;
		assert (header == exp_header) else begin
			$display("MISMATCH header exp=%h got=%h", exp_header, header);
			error_count++;
		end
		for (int k = 0; k < num_miners; k++) begin
			sn = exp_start_nonce(k);
			assert (start_nonces[k] == sn) else begin
				$display("MISMATCH start_nonces[%0d] exp=%h got=%h", k, sn, start_nonces[k]);
				error_count++;
			end
		end
	endtask

	// miner model with random nonces on every core and at most one finder
	task automatic drive_miners(input logic find);
		logic [31:0] v;
		logic [31:0] pick;
		miner_pkg::miner_result_t [num_miners-1:0] r;
		take_bits(2, pick);
		for (int k = 0; k < num_miners; k++) begin
			take_bits(32, v);
			r[k].nonce = v;
			r[k].found = find && (k == int'(pick) % num_miners);
		end
		@(posedge clk);
		results <= r;
		if (find && exp_armed) begin
			exp_stop <= 1'b1;
			exp_armed <= 1'b0;
		end
	endtask

	initial begin
		logic [31:0] v;
		bus = '0;
		results = '0;
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		read_byte(miner_pkg::addr_arm);
		read_byte(miner_pkg::addr_control);

		start_load(); // full random header
		for (int i = 0; i < miner_pkg::header_bytes; i++) begin
			take_bits(8, v);
			write_byte(8'(i), v[7:0]);
		end
		wait_load_done();
		check_job_outputs();
		for (int i = 0; i < 120; i++) begin
			read_byte(8'(i)); // header, status, control, arm, start nonces
		end
		read_byte(8'd200);
		read_byte(8'd255);

		drive_miners(1'b1);
		for (int i = 100; i < 170; i++) begin
			read_byte(8'(i));
		end

		drive_miners(1'b0); // stop keeps tracking once the finds are gone
		for (int i = 148; i < 168; i++) begin
			read_byte(8'(i));
		end

		start_load(); // only the closing byte so the rest stays cleared
		take_bits(8, v);
		write_byte(8'd95, v[7:0]);
		wait_load_done();
		check_job_outputs();
		for (int i = 0; i < 170; i++) begin
			read_byte(8'(i));
		end

		repeat (3) @(posedge clk);
		finish_run();
	end

endmodule

`default_nettype wire

// File: miner_ctrl.f
hw/miner_pkg.sv
hw/header_loader.sv
hw/nonce_allocator.sv
hw/result_capture.sv
hw/readback_mux.sv
hw/miner_ctrl_top.sv
testbench/miner_ctrl_sva.sv
testbench/miner_ctrl_tb.sv
